// File: filelist.f
+incdir+include
source/mipsPkg.sv
source/mipsStageIf.sv
source/mipsDecode.sv
source/mipsExecute.sv
source/mipsResult.sv
source/mipsCore.sv
tb/tbMemory.sv
tb/mipsCoreTb.sv

// File: include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000
// datapath and address width
`define MIPS_XLEN 32
// architectural gpr count
`define MIPS_NREG 32

//////////////////////////////////////////////////
// primary opcodes
//////////////////////////////////////////////////
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDIU 6'h09
`define OP_ORI 6'h0d
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b

//////////////////////////////////////////////////
// special funct codes
//////////////////////////////////////////////////
`define FN_MFHI 6'h10
`define FN_MTHI 6'h11
`define FN_MFLO 6'h12
`define FN_MTLO 6'h13
`define FN_MULT 6'h18
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

`endif

// File: source/mipsCore.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsCore (
	input logic clk,
	input logic rstN,
	input logic [`MIPS_XLEN-1:0] instrF,
	input logic [`MIPS_XLEN-1:0] readDataM,
	output logic [`MIPS_XLEN-1:0] pcF,
	output logic memWriteM,
	output logic [`MIPS_XLEN-1:0] aluOutM,
	output logic [`MIPS_XLEN-1:0] writeDataM,
	output logic [`MIPS_XLEN-1:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [`MIPS_XLEN-1:0] debugWbRfWdata
);
	// gpr write port from writeback
	logic rfWe;
	logic [4:0] rfWa;
	logic [`MIPS_XLEN-1:0] rfWd;

	//////////////////////////////////////////////////
	// stage bundles
	//////////////////////////////////////////////////
	idExIf deIf ();
	exWbIf ewIf ();

	// fetch, decode, hazards
	mipsDecode u_decode (
		.clk(clk),
		.rstN(rstN),
		.instrF(instrF),
		.rfWe(rfWe),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.pcF(pcF),
		.de(deIf.decode)
	);

	// execute plus memory-stage registers
	mipsExecute u_execute (
		.clk(clk),
		.rstN(rstN),
		.de(deIf.execute),
		.ew(ewIf.execute),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM)
	);

	// writeback, hi/lo, trace
	mipsResult u_result (
		.clk(clk),
		.rstN(rstN),
		.readDataM(readDataM),
		.ew(ewIf.result),
		.rfWe(rfWe),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

endmodule

// File: source/mipsDecode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsDecode import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	input logic [`MIPS_XLEN-1:0] instrF,
	input logic rfWe,
	input logic [4:0] rfWa,
	input logic [`MIPS_XLEN-1:0] rfWd,
	output logic [`MIPS_XLEN-1:0] pcF,
	idExIf.decode de
);
	// if/id state
	logic [`MIPS_XLEN-1:0] pcD;
	instrWord_u instrD;
	logic validD;
	// next pc
	logic [`MIPS_XLEN-1:0] pcPlus4F, pcPlus4D, pcNext, branchTarget, jumpTarget;
	// decoded controls
	aluOp_e aluOpD;
	resSel_e resSelD;
	logic aluSrcD, memWriteD, regWriteD, regDstD, multD, toHiD, toLoD;
	logic signExtD, beqD, bneD, jumpD, usesRsD, usesRtD;
	// operands
	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];
	logic [`MIPS_XLEN-1:0] rdA, rdB, cmpA, cmpB, immD;
	logic [4:0] rsD, rtD, rdD;
	logic branchTaken, loadUseStall, branchStall, stallD;

	//////////////////////////////////////////////////
	// fetch and if/id
	//////////////////////////////////////////////////

	assign pcPlus4F = pcF + 32'd4;
	assign pcPlus4D = pcD + 32'd4;
	assign branchTarget = pcPlus4D + {{14{instrD.iFields.imm16[15]}}, instrD.iFields.imm16, 2'b00};
	// upper pc bits plus the 26-bit index spread over rs, rt and imm16
	assign jumpTarget = {pcPlus4D[31:28], instrD.iFields.rs, instrD.iFields.rt,
		instrD.iFields.imm16, 2'b00};
	// redirect lands after the delay slot now in fetch
	assign pcNext = jumpD ? jumpTarget : branchTaken ? branchTarget : pcPlus4F;

	// stall holds pc and if/id together
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcF <= `MIPS_RESET_PC;
			pcD <= `MIPS_RESET_PC;
			instrD <= '0;
			validD <= 1'b0;
		end else if (!stallD) begin
			pcF <= pcNext;
			pcD <= pcF;
			instrD <= instrF;
			validD <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////

	always_comb begin
		aluOpD = ALU_PASS;
		resSelD = RES_ALU;
		{aluSrcD, memWriteD, regWriteD, regDstD, multD, toHiD, toLoD} = '0;
		{signExtD, beqD, bneD, jumpD, usesRtD} = '0;
		usesRsD = 1'b1;
		if (validD) begin
			case (instrD.rFields.op)
				`OP_RTYPE: begin
					regDstD = 1'b1;
					regWriteD = 1'b1;
					usesRtD = 1'b1;
					case (instrD.rFields.funct)
						`FN_ADDU: aluOpD = ALU_ADD;
						`FN_SUBU: aluOpD = ALU_SUB;
						`FN_AND: aluOpD = ALU_AND;
						`FN_OR: aluOpD = ALU_OR;
						`FN_SLT: aluOpD = ALU_SLT;
						`FN_MFHI: resSelD = RES_HI;
						`FN_MFLO: resSelD = RES_LO;
						// hi/lo writers leave the gpr file alone
						`FN_MULT: {multD, regWriteD} = 2'b10;
						`FN_MTHI: {toHiD, regWriteD} = 2'b10;
						`FN_MTLO: {toLoD, regWriteD} = 2'b10;
						// unknown funct runs as a nop
						default: regWriteD = 1'b0;
					endcase
				end
				`OP_ADDIU: {aluOpD, aluSrcD, regWriteD, signExtD} = {ALU_ADD, 3'b111};
				`OP_ORI: {aluOpD, aluSrcD, regWriteD} = {ALU_OR, 2'b11};
				`OP_LUI: {aluOpD, aluSrcD, regWriteD} = {ALU_LUI, 2'b11};
				`OP_LW: begin
					{aluOpD, aluSrcD, regWriteD, signExtD} = {ALU_ADD, 3'b111};
					resSelD = RES_MEM;
				end
				`OP_SW: {aluOpD, aluSrcD, memWriteD, signExtD, usesRtD} = {ALU_ADD, 4'b1111};
				`OP_BEQ: {beqD, usesRtD} = 2'b11;
				`OP_BNE: {bneD, usesRtD} = 2'b11;
				`OP_J: {jumpD, usesRsD} = 2'b10;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// register file, writeback bypass on read
	//////////////////////////////////////////////////

	assign rsD = instrD.rFields.rs;
	assign rtD = instrD.rFields.rt;
	assign rdD = instrD.rFields.rd;

	// r0 entry held at zero, writes to it dropped
	always_ff @(posedge clk) begin
		if (rfWe && rfWa != 5'd0)
			regs[rfWa] <= rfWd;
		regs[0] <= '0;
	end

	assign rdA = (rfWe && rfWa != 5'd0 && rfWa == rsD) ? rfWd : regs[rsD];
	assign rdB = (rfWe && rfWa != 5'd0 && rfWa == rtD) ? rfWd : regs[rtD];
	assign immD = signExtD ? {{16{instrD.iFields.imm16[15]}}, instrD.iFields.imm16}
		: {16'h0000, instrD.iFields.imm16};

	// branch compare, memory-stage alu result forwarded in
	assign cmpA = (de.regWriteM && !de.isLoadM && rsD != 5'd0 && de.writeRegM == rsD)
		? de.aluOutM : rdA;
	assign cmpB = (de.regWriteM && !de.isLoadM && rtD != 5'd0 && de.writeRegM == rtD)
		? de.aluOutM : rdB;
	assign branchTaken = (beqD && cmpA == cmpB) || (bneD && cmpA != cmpB);

	//////////////////////////////////////////////////
	// hazards
	//////////////////////////////////////////////////

	// late result in execute, consumer waits one cycle
	assign loadUseStall = de.isLoadE && de.writeRegE != 5'd0
		&& ((usesRsD && rsD == de.writeRegE) || (usesRtD && rtD == de.writeRegE));
	// branch waits for anything in execute and for a late result in memory
	assign branchStall = (beqD || bneD) && (
		(de.regWriteE && de.writeRegE != 5'd0 && (rsD == de.writeRegE || rtD == de.writeRegE))
		|| (de.isLoadM && de.writeRegM != 5'd0 && (rsD == de.writeRegM || rtD == de.writeRegM)));
	assign stallD = loadUseStall || branchStall;

	// bubble into id/ex on stall
	assign de.valid = validD && !stallD;
	assign de.aluOp = aluOpD;
	assign de.aluSrc = aluSrcD;
	assign de.memWrite = memWriteD;
	assign de.memToReg = resSelD;
	assign de.regWrite = regWriteD;
	assign de.writeReg = regDstD ? rdD : rtD;
	assign de.mult = multD;
	assign de.toHi = toHiD;
	assign de.toLo = toLoD;
	assign de.srcA = rdA;
	assign de.srcB = rdB;
	assign de.imm = immD;
	assign de.rs = rsD;
	assign de.rt = rtD;
	assign de.pc = pcD;

	// r0 stays zero even while writeback targets it
	r0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
		(rsD == 5'd0) |-> (de.srcA == '0));
	// redirects never break word alignment
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pcF[1:0] == 2'b00);

endmodule

// File: source/mipsExecute.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsExecute import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	idExIf.execute de,
	exWbIf.execute ew,
	output logic memWriteM,
	output logic [`MIPS_XLEN-1:0] aluOutM,
	output logic [`MIPS_XLEN-1:0] writeDataM
);
	// id/ex control
	logic regWriteE, memWriteE, multE, toHiE, toLoE, aluSrcE;
	aluOp_e aluOpE;
	resSel_e resSelE;
	logic [4:0] writeRegE, rsE, rtE;
	// id/ex payload
	logic [`MIPS_XLEN-1:0] srcAE, srcBE, immE, pcE;
	// operands and results
	logic [`MIPS_XLEN-1:0] opA, opB, aluB, aluOutE;
	logic [2*`MIPS_XLEN-1:0] productE;

	//////////////////////////////////////////////////
	// id/ex register
	//////////////////////////////////////////////////

	// bubbles arrive with valid low, gate every strobe
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			multE <= 1'b0;
			toHiE <= 1'b0;
			toLoE <= 1'b0;
		end else begin
			regWriteE <= de.valid && de.regWrite;
			memWriteE <= de.valid && de.memWrite;
			multE <= de.valid && de.mult;
			toHiE <= de.valid && de.toHi;
			toLoE <= de.valid && de.toLo;
		end
	end

	always_ff @(posedge clk) begin
		aluOpE <= de.aluOp;
		aluSrcE <= de.aluSrc;
		resSelE <= de.memToReg;
		writeRegE <= de.writeReg;
		rsE <= de.rs;
		rtE <= de.rt;
		srcAE <= de.srcA;
		srcBE <= de.srcB;
		immE <= de.imm;
		pcE <= de.pc;
	end

	//////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////

	// memory stage only forwards alu results, late ones were stalled for
	always_comb begin
		opA = srcAE;
		if (rsE != 5'd0 && ew.regWrite && ew.resSel == RES_ALU && ew.writeReg == rsE)
			opA = ew.aluOut;
		else if (rsE != 5'd0 && ew.regWriteW && ew.writeRegW == rsE)
			opA = ew.resultW;
		opB = srcBE;
		if (rtE != 5'd0 && ew.regWrite && ew.resSel == RES_ALU && ew.writeReg == rtE)
			opB = ew.aluOut;
		else if (rtE != 5'd0 && ew.regWriteW && ew.writeRegW == rtE)
			opB = ew.resultW;
	end

	//////////////////////////////////////////////////
	// alu and multiplier
	//////////////////////////////////////////////////

	assign aluB = aluSrcE ? immE : opB;

	always_comb begin
		case (aluOpE)
			ALU_ADD: aluOutE = opA + aluB;
			ALU_SUB: aluOutE = opA - aluB;
			ALU_AND: aluOutE = opA & aluB;
			ALU_OR: aluOutE = opA | aluB;
			ALU_SLT: aluOutE = {31'd0, $signed(opA) < $signed(aluB)};
			ALU_LUI: aluOutE = {aluB[15:0], 16'h0000};
			ALU_PASS: aluOutE = opA;
			default: aluOutE = '0;
		endcase
	end

	// signed 32x32, full width product
	assign productE = $signed(opA) * $signed(opB);

	//////////////////////////////////////////////////
	// ex/mem register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWriteM <= 1'b0;
			ew.regWrite <= 1'b0;
			ew.mult <= 1'b0;
			ew.toHi <= 1'b0;
			ew.toLo <= 1'b0;
		end else begin
			memWriteM <= memWriteE;
			ew.regWrite <= regWriteE;
			ew.mult <= multE;
			ew.toHi <= toHiE;
			ew.toLo <= toLoE;
		end
	end

	always_ff @(posedge clk) begin
		ew.writeReg <= writeRegE;
		ew.resSel <= resSelE;
		ew.aluOut <= aluOutE;
		ew.srcA <= opA;
		ew.product <= productE;
		ew.pc <= pcE;
		// store data is the forwarded rt
		writeDataM <= opB;
	end

	assign aluOutM = ew.aluOut;

	// hazard status back to decode
	assign de.writeRegE = writeRegE;
	assign de.regWriteE = regWriteE;
	assign de.isLoadE = regWriteE && resSelE != RES_ALU;
	assign de.writeRegM = ew.writeReg;
	assign de.regWriteM = ew.regWrite;
	assign de.isLoadM = ew.regWrite && ew.resSel != RES_ALU;
	assign de.aluOutM = ew.aluOut;

	// a store never also claims a gpr write
	storeNoRegWrite: assert property (@(posedge clk) disable iff (!rstN)
		!(memWriteM && ew.regWrite));

endmodule

// File: source/mipsPkg.sv
package mipsPkg;

	//////////////////////////////////////////////////
	// instruction word views
	//////////////////////////////////////////////////

	// register format
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	// immediate format, also reused for the jump index
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFields_t;

	// one fetched word, decoded either way
	typedef union packed {
		rFields_t rFields;
		iFields_t iFields;
	} instrWord_u;

	//////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////

	// alu function for execute
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI,
		ALU_PASS
	} aluOp_e;

	// writeback source
	typedef enum logic [1:0] {
		RES_ALU,
		RES_MEM,
		RES_HI,
		RES_LO
	} resSel_e;

endpackage

// File: source/mipsResult.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsResult import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	input logic [`MIPS_XLEN-1:0] readDataM,
	exWbIf.result ew,
	output logic rfWe,
	output logic [4:0] rfWa,
	output logic [`MIPS_XLEN-1:0] rfWd,
	output logic [`MIPS_XLEN-1:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [`MIPS_XLEN-1:0] debugWbRfWdata
);
	// mem/wb state
	logic regWriteW, multW, toHiW, toLoW;
	logic [4:0] writeRegW;
	resSel_e resSelW;
	logic [`MIPS_XLEN-1:0] aluOutW, readDataW, srcAW, pcW, resultW;
	logic [2*`MIPS_XLEN-1:0] productW;
	// hi/lo pair
	logic [`MIPS_XLEN-1:0] hi, lo;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regWriteW <= 1'b0;
			multW <= 1'b0;
			toHiW <= 1'b0;
			toLoW <= 1'b0;
		end else begin
			regWriteW <= ew.regWrite;
			multW <= ew.mult;
			toHiW <= ew.toHi;
			toLoW <= ew.toLo;
		end
	end

	always_ff @(posedge clk) begin
		writeRegW <= ew.writeReg;
		resSelW <= ew.resSel;
		aluOutW <= ew.aluOut;
		srcAW <= ew.srcA;
		productW <= ew.product;
		pcW <= ew.pc;
		// load data sampled at the end of memory
		readDataW <= readDataM;
	end

	//////////////////////////////////////////////////
	// hi/lo, updated as writeback ends
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (multW) begin
			hi <= productW[2*`MIPS_XLEN-1:`MIPS_XLEN];
			lo <= productW[`MIPS_XLEN-1:0];
		end else begin
			if (toHiW)
				hi <= srcAW;
			if (toLoW)
				lo <= srcAW;
		end
	end

	// result select
	always_comb begin
		case (resSelW)
			RES_MEM: resultW = readDataW;
			RES_HI: resultW = hi;
			RES_LO: resultW = lo;
			default: resultW = aluOutW;
		endcase
	end

	assign rfWe = regWriteW;
	assign rfWa = writeRegW;
	assign rfWd = resultW;
	assign ew.regWriteW = regWriteW;
	assign ew.writeRegW = writeRegW;
	assign ew.resultW = resultW;

	// trace mirrors the gpr write, all byte lanes
	assign debugWbPc = pcW;
	assign debugWbRfWen = {4{regWriteW}};
	assign debugWbRfWnum = writeRegW;
	assign debugWbRfWdata = resultW;

	// only one hi/lo writer per instruction
	hiLoOneWriter: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({toHiW, toLoW, multW}));

endmodule

// File: source/mipsStageIf.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

// decode to execute bundle, hazard feedback comes back the other way
interface idExIf import mipsPkg::*; ();
	logic valid;
	aluOp_e aluOp;
	logic aluSrc;
	logic memWrite;
	resSel_e memToReg;
	logic regWrite;
	logic [4:0] writeReg;
	logic mult;
	logic toHi;
	logic toLo;
	logic [`MIPS_XLEN-1:0] srcA;
	logic [`MIPS_XLEN-1:0] srcB;
	logic [`MIPS_XLEN-1:0] imm;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [`MIPS_XLEN-1:0] pc;
	// execute and memory stage status for stalls and branch forwarding
	logic [4:0] writeRegE;
	logic regWriteE;
	logic isLoadE;
	logic [4:0] writeRegM;
	logic regWriteM;
	logic isLoadM;
	logic [`MIPS_XLEN-1:0] aluOutM;

	modport decode (
		output valid, aluOp, aluSrc, memWrite, memToReg, regWrite, writeReg,
		output mult, toHi, toLo, srcA, srcB, imm, rs, rt, pc,
		input writeRegE, regWriteE, isLoadE, writeRegM, regWriteM, isLoadM, aluOutM
	);
	modport execute (
		input valid, aluOp, aluSrc, memWrite, memToReg, regWrite, writeReg,
		input mult, toHi, toLo, srcA, srcB, imm, rs, rt, pc,
		output writeRegE, regWriteE, isLoadE, writeRegM, regWriteM, isLoadM, aluOutM
	);
endinterface

// memory stage bundle into writeback, writeback forwarding comes back
interface exWbIf import mipsPkg::*; ();
	logic regWrite;
	logic [4:0] writeReg;
	resSel_e resSel;
	logic [`MIPS_XLEN-1:0] aluOut;
	logic [`MIPS_XLEN-1:0] srcA;
	logic mult;
	logic [2*`MIPS_XLEN-1:0] product;
	logic toHi;
	logic toLo;
	logic [`MIPS_XLEN-1:0] pc;
	logic regWriteW;
	logic [4:0] writeRegW;
	logic [`MIPS_XLEN-1:0] resultW;

	modport execute (
		output regWrite, writeReg, resSel, aluOut, srcA, mult, product, toHi, toLo, pc,
		input regWriteW, writeRegW, resultW
	);
	modport result (
		input regWrite, writeReg, resSel, aluOut, srcA, mult, product, toHi, toLo, pc,
		output regWriteW, writeRegW, resultW
	);
endinterface

// File: tb/mipsCoreTb.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsCoreTb import mipsPkg::*; ();
	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS = 6;
	localparam int MAX_INSTR = 64;
	localparam int CYCLES_PER_INSTR = 3;
	localparam int MARGIN = 200 * CLK_PERIOD;

	logic clk, rstN;
	logic [`MIPS_XLEN-1:0] instrF, readDataM, pcF, aluOutM, writeDataM;
	logic memWriteM;
	logic [`MIPS_XLEN-1:0] debugWbPc, debugWbRfWdata;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;

	// program image under construction
	logic [31:0] prog [256];
	int progLen;
	// reference state, persists across tests like the dut regfile and ram
	logic [31:0] refReg [32];
	logic [31:0] refMem [256];
	logic [31:0] refHi, refLo;
	logic [31:0] rngState;
	// expected and observed traces
	logic [31:0] expPc[$], expNum[$], expData[$], expAddr[$], expStore[$];
	logic [31:0] gotPc[$], gotNum[$], gotData[$], gotEn[$], gotAddr[$], gotStore[$];
	int errorCount, passCount, failCount;

	mipsCore u_dut (
		.clk(clk),
		.rstN(rstN),
		.instrF(instrF),
		.readDataM(readDataM),
		.pcF(pcF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	tbMemory u_mem (
		.clk(clk),
		.pcF(pcF),
		.instrF(instrF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.readDataM(readDataM)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// budget from test count and program length
	initial begin
		#(NUM_TESTS * MAX_INSTR * CYCLES_PER_INSTR * CLK_PERIOD + MARGIN);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	// mid-cycle sampling of the trace and store strobes
	always @(negedge clk) begin
		if (debugWbRfWen != 4'h0) begin
			gotPc.push_back(debugWbPc);
			gotNum.push_back({27'd0, debugWbRfWnum});
			gotData.push_back(debugWbRfWdata);
			gotEn.push_back({28'd0, debugWbRfWen});
		end
		if (memWriteM) begin
			gotAddr.push_back(aluOutM);
			gotStore.push_back(writeDataM);
		end
	end

	//////////////////////////////////////////////////
	// assembler helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] encodeR(logic [5:0] funct, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
		instrWord_u w;
		w.rFields.op = `OP_RTYPE;
		w.rFields.rs = rs;
		w.rFields.rt = rt;
		w.rFields.rd = rd;
		w.rFields.shamt = 5'd0;
		w.rFields.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
		logic [15:0] imm);
		instrWord_u w;
		w.iFields.op = op;
		w.iFields.rs = rs;
		w.iFields.rt = rt;
		w.iFields.imm16 = imm;
		return w;
	endfunction

	// word index of the target, 26 bits over rs, rt and imm16
	function automatic logic [31:0] encodeJ(logic [25:0] index);
		instrWord_u w;
		w.iFields.op = `OP_J;
		{w.iFields.rs, w.iFields.rt, w.iFields.imm16} = index;
		return w;
	endfunction

	task automatic appendWord(logic [31:0] word);
		prog[progLen] = word;
		progLen++;
	endtask

	function automatic logic [31:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	//////////////////////////////////////////////////
	// instruction-level reference model
	//////////////////////////////////////////////////

	// r0 writes still show on the trace
	task automatic modelWrite(logic [4:0] num, logic [31:0] value, logic [31:0] pc);
		expPc.push_back(pc);
		expNum.push_back({27'd0, num});
		expData.push_back(value);
		if (num != 5'd0)
			refReg[num] = value;
	endtask

	task automatic runModel();
		logic [31:0] pc, npc, target, a, b, sImm, zImm, addr;
		logic [63:0] product;
		instrWord_u w;
		int steps;
		pc = `MIPS_RESET_PC;
		npc = pc + 32'd4;
		steps = 0;
		expPc.delete();
		expNum.delete();
		expData.delete();
		expAddr.delete();
		expStore.delete();
		while ((pc >> 2) < progLen && steps < 2 * MAX_INSTR) begin
			w = prog[pc[9:2]];
			a = refReg[w.rFields.rs];
			b = refReg[w.rFields.rt];
			sImm = {{16{w.iFields.imm16[15]}}, w.iFields.imm16};
			zImm = {16'h0000, w.iFields.imm16};
			addr = a + sImm;
			// delay slot at npc always runs, redirect applies after it
			target = npc + 32'd4;
			case (w.rFields.op)
				`OP_RTYPE: case (w.rFields.funct)
					`FN_ADDU: modelWrite(w.rFields.rd, a + b, pc);
					`FN_SUBU: modelWrite(w.rFields.rd, a - b, pc);
					`FN_AND: modelWrite(w.rFields.rd, a & b, pc);
					`FN_OR: modelWrite(w.rFields.rd, a | b, pc);
					`FN_SLT: modelWrite(w.rFields.rd, {31'd0, $signed(a) < $signed(b)}, pc);
					`FN_MFHI: modelWrite(w.rFields.rd, refHi, pc);
					`FN_MFLO: modelWrite(w.rFields.rd, refLo, pc);
					`FN_MTHI: refHi = a;
					`FN_MTLO: refLo = a;
					`FN_MULT: begin
						product = $signed(a) * $signed(b);
						refHi = product[63:32];
						refLo = product[31:0];
					end
					default: ;
				endcase
				`OP_ADDIU: modelWrite(w.iFields.rt, a + sImm, pc);
				`OP_ORI: modelWrite(w.iFields.rt, a | zImm, pc);
				`OP_LUI: modelWrite(w.iFields.rt, {w.iFields.imm16, 16'h0000}, pc);
				`OP_LW: modelWrite(w.iFields.rt, refMem[addr[9:2]], pc);
				`OP_SW: begin
					refMem[addr[9:2]] = b;
					expAddr.push_back(addr);
					expStore.push_back(b);
				end
				`OP_BEQ: if (a == b) target = npc + (sImm << 2);
				`OP_BNE: if (a != b) target = npc + (sImm << 2);
				`OP_J: target = {npc[31:28], w.iFields.rs, w.iFields.rt, w.iFields.imm16, 2'b00};
				default: ;
			endcase
			pc = npc;
			npc = target;
			steps++;
		end
	endtask

	//////////////////////////////////////////////////
	// run and compare
	//////////////////////////////////////////////////

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %08h expected %08h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic runProgram(string name);
		int cycles;
		int errorsBefore;
		int n;
		errorsBefore = errorCount;
		@(posedge clk);
		rstN <= 1'b0;
		// rom changes only while the core is held in reset
		@(negedge clk);
		// fetch address held at the reset vector
		check("pcF", pcF, `MIPS_RESET_PC);
		for (int i = 0; i < 256; i++)
			u_mem.rom[i] = (i < progLen) ? prog[i] : 32'h0;
		runModel();
		@(posedge clk);
		gotPc.delete();
		gotNum.delete();
		gotData.delete();
		gotEn.delete();
		gotAddr.delete();
		gotStore.delete();
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		cycles = 0;
		while (gotNum.size() < expNum.size() && cycles < MAX_INSTR * CYCLES_PER_INSTR) begin
			@(posedge clk);
			cycles++;
		end
		// tail drain, extra writes would land here
		repeat (8) @(posedge clk);
		if (gotNum.size() != expNum.size()) begin
			$display("%s: saw %0d register writes where %0d were expected", name,
				gotNum.size(), expNum.size());
			errorCount++;
		end
		if (gotAddr.size() != expAddr.size()) begin
			$display("%s: saw %0d stores where %0d were expected", name,
				gotAddr.size(), expAddr.size());
			errorCount++;
		end
		n = (gotNum.size() < expNum.size()) ? gotNum.size() : expNum.size();
		for (int i = 0; i < n; i++) begin
			check($sformatf("debugWbPc[%0d]", i), gotPc[i], expPc[i]);
			check($sformatf("debugWbRfWnum[%0d]", i), gotNum[i], expNum[i]);
			check($sformatf("debugWbRfWdata[%0d]", i), gotData[i], expData[i]);
			check($sformatf("debugWbRfWen[%0d]", i), gotEn[i], 32'hf);
		end
		n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
		for (int i = 0; i < n; i++) begin
			check($sformatf("aluOutM[%0d]", i), gotAddr[i], expAddr[i]);
			check($sformatf("writeDataM[%0d]", i), gotStore[i], expStore[i]);
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %s: ok, %0d writes and %0d stores matched", name,
				expNum.size(), expAddr.size());
		end else begin
			failCount++;
			$display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic aluTest();
		progLen = 0;
		appendWord(encodeI(`OP_ADDIU, 5'd1, 5'd0, 16'h1234));
		appendWord(encodeI(`OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
		appendWord(encodeI(`OP_LUI, 5'd3, 5'd0, 16'h8001));
		appendWord(encodeI(`OP_ORI, 5'd4, 5'd0, 16'hf0f0));
		// gap so nothing below forwards
		repeat (3) appendWord(32'h0);
		appendWord(encodeR(`FN_ADDU, 5'd5, 5'd1, 5'd2));
		appendWord(encodeR(`FN_SUBU, 5'd6, 5'd1, 5'd2));
		appendWord(encodeR(`FN_AND, 5'd7, 5'd2, 5'd4));
		appendWord(encodeR(`FN_OR, 5'd8, 5'd3, 5'd4));
		appendWord(encodeR(`FN_SLT, 5'd9, 5'd2, 5'd1));
		appendWord(encodeR(`FN_SLT, 5'd10, 5'd3, 5'd1));
		appendWord(encodeR(`FN_SLT, 5'd11, 5'd1, 5'd2));
		appendWord(encodeI(`OP_ADDIU, 5'd12, 5'd1, 16'h8000));
		appendWord(encodeI(`OP_ORI, 5'd13, 5'd2, 16'h8000));
		appendWord(encodeI(`OP_LUI, 5'd14, 5'd0, 16'h7fff));
		runProgram("alu");
	endtask

	task automatic forwardTest();
		progLen = 0;
		appendWord(encodeI(`OP_ADDIU, 5'd1, 5'd0, 16'h0007));
		appendWord(encodeI(`OP_ADDIU, 5'd2, 5'd1, 16'h0003));
		appendWord(encodeR(`FN_ADDU, 5'd3, 5'd2, 5'd1));
		appendWord(encodeR(`FN_SUBU, 5'd4, 5'd3, 5'd3));
		// r0 target, later reads must stay zero
		appendWord(encodeR(`FN_ADDU, 5'd0, 5'd1, 5'd2));
		appendWord(encodeR(`FN_ADDU, 5'd5, 5'd0, 5'd1));
		appendWord(encodeR(`FN_OR, 5'd6, 5'd0, 5'd0));
		appendWord(encodeI(`OP_ADDIU, 5'd7, 5'd4, 16'hffff));
		appendWord(encodeR(`FN_AND, 5'd8, 5'd7, 5'd2));
		runProgram("forward");
	endtask

	task automatic memoryTest();
		progLen = 0;
		appendWord(encodeI(`OP_ADDIU, 5'd1, 5'd0, 16'h0040));
		appendWord(encodeI(`OP_LUI, 5'd2, 5'd0, 16'hdead));
		appendWord(encodeI(`OP_ORI, 5'd2, 5'd2, 16'hbeef));
		appendWord(encodeI(`OP_SW, 5'd2, 5'd1, 16'h0000));
		appendWord(encodeI(`OP_SW, 5'd1, 5'd1, 16'h0004));
		appendWord(encodeI(`OP_LW, 5'd3, 5'd1, 16'h0000));
		// load-use on an alu op, then on store data
		appendWord(encodeR(`FN_ADDU, 5'd4, 5'd3, 5'd3));
		appendWord(encodeI(`OP_LW, 5'd5, 5'd1, 16'h0004));
		appendWord(encodeI(`OP_SW, 5'd5, 5'd1, 16'h0008));
		appendWord(encodeI(`OP_LW, 5'd6, 5'd1, 16'h0008));
		appendWord(32'h0);
		appendWord(encodeR(`FN_OR, 5'd7, 5'd6, 5'd3));
		runProgram("memory");
	endtask

	task automatic branchTest();
		progLen = 0;
		appendWord(encodeI(`OP_ADDIU, 5'd1, 5'd0, 16'h0001));
		appendWord(encodeI(`OP_ADDIU, 5'd2, 5'd0, 16'h0002));
		appendWord(32'h0);
		// not taken beq
		appendWord(encodeI(`OP_BEQ, 5'd2, 5'd1, 16'h0002));
		appendWord(encodeI(`OP_ADDIU, 5'd3, 5'd0, 16'h0003));
		appendWord(encodeI(`OP_ADDIU, 5'd4, 5'd0, 16'h0004));
		// taken bne skips index 8
		appendWord(encodeI(`OP_BNE, 5'd2, 5'd1, 16'h0002));
		appendWord(encodeI(`OP_ADDIU, 5'd5, 5'd0, 16'h0005));
		appendWord(encodeI(`OP_ADDIU, 5'd6, 5'd0, 16'h0006));
		// taken beq on the result just before it
		appendWord(encodeI(`OP_ADDIU, 5'd7, 5'd1, 16'h0001));
		appendWord(encodeI(`OP_BEQ, 5'd2, 5'd7, 16'h0002));
		appendWord(encodeI(`OP_ADDIU, 5'd8, 5'd0, 16'h0008));
		appendWord(encodeI(`OP_ADDIU, 5'd9, 5'd0, 16'h0009));
		appendWord(encodeI(`OP_BNE, 5'd2, 5'd7, 16'h0002));
		appendWord(encodeI(`OP_ADDIU, 5'd10, 5'd0, 16'h000a));
		appendWord(encodeI(`OP_ADDIU, 5'd11, 5'd0, 16'h000b));
		appendWord(encodeJ(26'd19));
		appendWord(encodeI(`OP_ADDIU, 5'd12, 5'd0, 16'h000c));
		appendWord(encodeI(`OP_ADDIU, 5'd13, 5'd0, 16'h000d));
		appendWord(encodeI(`OP_ADDIU, 5'd14, 5'd0, 16'h000e));
		// branch on a fresh load, two-cycle wait
		appendWord(encodeI(`OP_SW, 5'd1, 5'd0, 16'h0080));
		appendWord(encodeI(`OP_LW, 5'd15, 5'd0, 16'h0080));
		appendWord(encodeI(`OP_BEQ, 5'd1, 5'd15, 16'h0002));
		appendWord(encodeI(`OP_ADDIU, 5'd16, 5'd0, 16'h0010));
		appendWord(encodeI(`OP_ADDIU, 5'd17, 5'd0, 16'h0011));
		appendWord(encodeI(`OP_ADDIU, 5'd18, 5'd0, 16'h0012));
		runProgram("branch");
	endtask

	task automatic hiLoTest();
		progLen = 0;
		appendWord(encodeI(`OP_LUI, 5'd1, 5'd0, 16'hffff));
		appendWord(encodeI(`OP_ORI, 5'd1, 5'd1, 16'hfff0));
		appendWord(encodeI(`OP_LUI, 5'd2, 5'd0, 16'h0012));
		appendWord(encodeI(`OP_ORI, 5'd2, 5'd2, 16'h3456));
		// negative times positive
		appendWord(encodeR(`FN_MULT, 5'd0, 5'd1, 5'd2));
		appendWord(encodeR(`FN_MFHI, 5'd3, 5'd0, 5'd0));
		appendWord(encodeR(`FN_MFLO, 5'd4, 5'd0, 5'd0));
		appendWord(encodeI(`OP_ADDIU, 5'd5, 5'd0, 16'h0055));
		appendWord(encodeR(`FN_MTHI, 5'd0, 5'd5, 5'd0));
		appendWord(encodeR(`FN_MTLO, 5'd0, 5'd2, 5'd0));
		appendWord(encodeR(`FN_MFHI, 5'd6, 5'd0, 5'd0));
		appendWord(encodeR(`FN_MFLO, 5'd7, 5'd0, 5'd0));
		appendWord(encodeR(`FN_ADDU, 5'd8, 5'd6, 5'd7));
		appendWord(encodeR(`FN_MULT, 5'd0, 5'd2, 5'd2));
		appendWord(encodeR(`FN_MFLO, 5'd9, 5'd0, 5'd0));
		appendWord(encodeR(`FN_MFHI, 5'd10, 5'd0, 5'd0));
		runProgram("hilo");
	endtask

	task automatic randomTest();
		logic [31:0] r;
		logic [4:0] rd, rs, rt;
		progLen = 0;
		// seed r1..r7 before any random read
		for (int i = 1; i < 8; i++) begin
			r = xorshift();
			appendWord(encodeI(`OP_ADDIU, i[4:0], 5'd0, r[15:0]));
		end
		for (int i = 0; i < 48; i++) begin
			r = xorshift();
			rd = {2'b00, r[2:0]};
			rs = {2'b00, r[5:3]};
			rt = {2'b00, r[8:6]};
			case (r[11:9])
				3'd0: appendWord(encodeR(`FN_ADDU, rd, rs, rt));
				3'd1: appendWord(encodeR(`FN_SUBU, rd, rs, rt));
				3'd2: appendWord(encodeR(`FN_AND, rd, rs, rt));
				3'd3: appendWord(encodeR(`FN_OR, rd, rs, rt));
				3'd4: appendWord(encodeR(`FN_SLT, rd, rs, rt));
				3'd5: appendWord(encodeI(`OP_ADDIU, rd, rs, r[31:16]));
				3'd6: appendWord(encodeI(`OP_ORI, rd, rs, r[31:16]));
				default: appendWord(encodeI(`OP_LUI, rd, 5'd0, r[31:16]));
			endcase
		end
		runProgram("random");
	endtask

	initial begin
		rstN = 1'b0;
		rngState = 32'h6369;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		for (int i = 0; i < 32; i++)
			refReg[i] = '0;
		for (int i = 0; i < 256; i++)
			refMem[i] = '0;
		aluTest();
		forwardTest();
		memoryTest();
		branchTest();
		hiLoTest();
		randomTest();
		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: tb/tbMemory.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tbMemory (
	input logic clk,
	input logic [`MIPS_XLEN-1:0] pcF,
	output logic [`MIPS_XLEN-1:0] instrF,
	input logic memWriteM,
	input logic [`MIPS_XLEN-1:0] aluOutM,
	input logic [`MIPS_XLEN-1:0] writeDataM,
	output logic [`MIPS_XLEN-1:0] readDataM
);
	// program store, loaded by the testbench during reset
	logic [`MIPS_XLEN-1:0] rom [256];
	// word data memory
	logic [`MIPS_XLEN-1:0] ram [256];

	initial begin
		for (int i = 0; i < 256; i++) begin
			rom[i] = '0;
			ram[i] = '0;
		end
	end

	//////////////////////////////////////////////////
	// instruction side
	//////////////////////////////////////////////////

	// all-zero word decodes as a nop, also past the rom
	assign instrF = (pcF[31:10] == '0) ? rom[pcF[9:2]] : '0;

	//////////////////////////////////////////////////
	// data side
	//////////////////////////////////////////////////

	// same-cycle read
	assign readDataM = ram[aluOutM[9:2]];

	always @(posedge clk) begin
		if (memWriteM)
			ram[aluOutM[9:2]] <= writeDataM;
	end

endmodule
